//--- src/calc_pkg.sv
`default_nettype none

package calc_pkg;

  localparam int data_width = 32;

  // Depth of the completion pipe, the last stage is the retire stage
  localparam int comp_stage_els = 4;

  // Stages where the fixed pipes merge their results
  localparam int int_stage = 1;
  localparam int mul_stage = 3;

  localparam int div_steps = 32;

  typedef logic [data_width-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    add    = 4'h0,
    sub    = 4'h1,
    and_op = 4'h2,
    or_op  = 4'h3,
    xor_op = 4'h4,
    slt    = 4'h5,
    mul    = 4'h6,
    divu   = 4'h7,
    remu   = 4'h8
  } op_e;

  typedef struct packed {
    logic      valid;
    op_e       op;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1;
    word_t     rs2;
  } dispatch_pkt_s;

  typedef struct packed {
    logic      ird_w_v;
    reg_addr_t rd_addr;
    word_t     rd_data;
  } wb_pkt_s;

  // Ops that go to the long unit instead of the completion pipe
  function automatic logic is_long_op(op_e op);
    return (op == divu) || (op == remu);
  endfunction

endpackage

`default_nettype wire

//--- src/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass
  (input logic                                             clk_i
  , input calc_pkg::dispatch_pkt_s                         dispatch_pkt_i
  , input calc_pkg::wb_pkt_s [calc_pkg::comp_stage_els-1:0] comp_stage_i
  , input calc_pkg::word_t [calc_pkg::comp_stage_els-1:0]   comp_data_next_i
  , output calc_pkg::dispatch_pkt_s                        reservation_o
  );

  import calc_pkg::*;

  logic [1:0][comp_stage_els-1:0] match_rs;
  logic [1:0][comp_stage_els:0]   match_onehot;
  logic [1:0]                     match_taken;
  word_t [1:0]                    dispatch_data;
  word_t [1:0]                    bypass_rs;
  dispatch_pkt_s                  reservation_n;

  assign dispatch_data = {dispatch_pkt_i.rs2, dispatch_pkt_i.rs1};

  for (genvar i = 0; i < comp_stage_els; i++)
  begin : match
    assign match_rs[0][i] = dispatch_pkt_i.valid & comp_stage_i[i].ird_w_v
                            & (dispatch_pkt_i.rs1_addr == comp_stage_i[i].rd_addr);
    assign match_rs[1][i] = dispatch_pkt_i.valid & comp_stage_i[i].ird_w_v
                            & (dispatch_pkt_i.rs2_addr == comp_stage_i[i].rd_addr);
  end

  // Stage 0 is the youngest producer, the top bit selects the dispatched value
  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      match_taken[s] = 1'b0;
      for (int i = 0; i < comp_stage_els; i++)
      begin
        match_onehot[s][i] = match_rs[s][i] & ~match_taken[s];
        match_taken[s]     = match_taken[s] | match_rs[s][i];
      end
      match_onehot[s][comp_stage_els] = ~match_taken[s];
    end
  end

  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      bypass_rs[s] = match_onehot[s][comp_stage_els] ? dispatch_data[s] : '0;
      for (int i = 0; i < comp_stage_els; i++)
      begin
        bypass_rs[s] |= match_onehot[s][i] ? comp_data_next_i[i] : '0;
      end
    end
  end

  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.rs1 = bypass_rs[0];
    reservation_n.rs2 = bypass_rs[1];
  end

  always_ff @(posedge clk_i)
  begin
    reservation_o <= reservation_n;
  end

endmodule

`default_nettype wire

//--- src/pipe_int.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_int
  (input logic                     clk_i
  , input logic                    rst_i
  , input calc_pkg::dispatch_pkt_s reservation_i
  , output calc_pkg::word_t        data_o
  , output logic                   v_o
  );

  import calc_pkg::*;

  logic alu_op;

  always_comb
  begin
    alu_op = 1'b1;
    case (reservation_i.op)
      add:    data_o = reservation_i.rs1 + reservation_i.rs2;
      sub:    data_o = reservation_i.rs1 - reservation_i.rs2;
      and_op: data_o = reservation_i.rs1 & reservation_i.rs2;
      or_op:  data_o = reservation_i.rs1 | reservation_i.rs2;
      xor_op: data_o = reservation_i.rs1 ^ reservation_i.rs2;
      // Signed compare, result is 0 or 1
      slt:    data_o = word_t'($signed(reservation_i.rs1) < $signed(reservation_i.rs2));
      default:
      begin
        data_o = '0;
        alu_op = 1'b0;
      end
    endcase
  end

  assign v_o = reservation_i.valid & alu_op;

endmodule

`default_nettype wire

//--- src/pipe_mul.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_mul
  (input logic                     clk_i
  , input logic                    rst_i
  , input calc_pkg::dispatch_pkt_s reservation_i
  , output calc_pkg::word_t        data_o
  , output logic                   v_o
  );

  import calc_pkg::*;

  logic  op_v_r;
  logic  prod_v_r;
  word_t rs1_r;
  word_t rs2_r;
  word_t prod_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      op_v_r   <= 1'b0;
      prod_v_r <= 1'b0;
    end
    else
    begin
      op_v_r   <= reservation_i.valid & (reservation_i.op == mul);
      prod_v_r <= op_v_r;
    end
  end

  // Only the low word of the product is kept
  always_ff @(posedge clk_i)
  begin
    rs1_r  <= reservation_i.rs1;
    rs2_r  <= reservation_i.rs2;
    prod_r <= rs1_r * rs2_r;
  end

  assign data_o = prod_r;
  assign v_o    = prod_v_r;

endmodule

`default_nettype wire

//--- src/pipe_long.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_long
  (input logic                     clk_i
  , input logic                    rst_i
  , input calc_pkg::dispatch_pkt_s reservation_i
  , output logic                   ready_o
  , output calc_pkg::wb_pkt_s      wb_pkt_o
  , output logic                   v_o
  , input logic                    yumi_i
  );

  import calc_pkg::*;

  localparam int cnt_width = $clog2(div_steps);

  typedef enum logic [1:0] {idle, busy, done} long_div_state_e;

  long_div_state_e        state_r;
  long_div_state_e        state_n;
  logic [cnt_width-1:0]   cnt_r;
  word_t                  quot_r;
  word_t                  rem_r;
  word_t                  divisor_r;
  logic                   rem_sel_r;
  reg_addr_t              rd_addr_r;
  logic [data_width:0]    rem_shift;
  logic [data_width:0]    rem_diff;
  logic                   long_req;
  logic                   accept;

  assign long_req = reservation_i.valid & is_long_op(reservation_i.op);
  assign accept   = (state_r == idle) & long_req;

  // Drops as soon as a divide sits in the reservation register
  assign ready_o = (state_r == idle) & ~long_req;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      idle:    if (accept) state_n = busy;
      busy:    if (cnt_r == '0) state_n = done;
      done:    if (yumi_i) state_n = idle;
      default: state_n = idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_r <= idle;
    else
      state_r <= state_n;
  end

  // Restoring shift-subtract step
  // A zero divisor leaves all ones and the dividend
  assign rem_shift = {rem_r, quot_r[data_width-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_r};

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      quot_r    <= reservation_i.rs1;
      rem_r     <= '0;
      divisor_r <= reservation_i.rs2;
      rem_sel_r <= (reservation_i.op == remu);
      rd_addr_r <= reservation_i.rd_addr;
      cnt_r     <= cnt_width'(div_steps - 1);
    end
    else if (state_r == busy)
    begin
      cnt_r <= cnt_r - cnt_width'(1);
      if (rem_diff[data_width])
      begin
        rem_r  <= rem_shift[data_width-1:0];
        quot_r <= {quot_r[data_width-2:0], 1'b0};
      end
      else
      begin
        rem_r  <= rem_diff[data_width-1:0];
        quot_r <= {quot_r[data_width-2:0], 1'b1};
      end
    end
  end

  assign v_o = (state_r == done);

  always_comb
  begin
    wb_pkt_o.ird_w_v = v_o;
    wb_pkt_o.rd_addr = rd_addr_r;
    wb_pkt_o.rd_data = rem_sel_r ? rem_r : quot_r;
  end

endmodule

`default_nettype wire

//--- src/completion_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module completion_pipe
  (input logic                                               clk_i
  , input logic                                              rst_i
  , input calc_pkg::dispatch_pkt_s                           reservation_i
  , input calc_pkg::word_t                                   int_data_i
  , input logic                                              int_v_i
  , input calc_pkg::word_t                                   mul_data_i
  , input logic                                              mul_v_i
  , output calc_pkg::wb_pkt_s [calc_pkg::comp_stage_els-1:0] comp_stage_o
  , output calc_pkg::word_t [calc_pkg::comp_stage_els-1:0]   comp_data_next_o
  );

  import calc_pkg::*;

  wb_pkt_s [comp_stage_els:0]     comp_stage_n;
  logic [comp_stage_els-1:0]      stage_v_r;
  reg_addr_t [comp_stage_els-1:0] stage_addr_r;
  word_t [comp_stage_els-1:0]     stage_data_r;

  always_comb
  begin
    comp_stage_n[0].ird_w_v = reservation_i.valid & ~is_long_op(reservation_i.op);
    comp_stage_n[0].rd_addr = reservation_i.rd_addr;
    comp_stage_n[0].rd_data = '0;
    for (int i = 1; i <= comp_stage_els; i++)
    begin
      comp_stage_n[i] = comp_stage_o[i-1];
    end
    // Single issue with fixed latencies, so at most one result per stage
    comp_stage_n[int_stage].rd_data |= int_v_i ? int_data_i : '0;
    comp_stage_n[mul_stage].rd_data |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < comp_stage_els; i++)
    begin
      if (rst_i)
        stage_v_r[i] <= 1'b0;
      else
        stage_v_r[i] <= comp_stage_n[i].ird_w_v;
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < comp_stage_els; i++)
    begin
      stage_addr_r[i] <= comp_stage_n[i].rd_addr;
      stage_data_r[i] <= comp_stage_n[i].rd_data;
    end
  end

  for (genvar i = 0; i < comp_stage_els; i++)
  begin : stage_out
    assign comp_stage_o[i].ird_w_v  = stage_v_r[i];
    assign comp_stage_o[i].rd_addr  = stage_addr_r[i];
    assign comp_stage_o[i].rd_data  = stage_data_r[i];
    // What stage i will hold after the next shift
    assign comp_data_next_o[i]      = comp_stage_n[i+1].rd_data;
  end

endmodule

`default_nettype wire

//--- src/wb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
  (input logic                 clk_i
  , input logic                rst_i
  , input calc_pkg::wb_pkt_s   retire_pkt_i
  , input calc_pkg::wb_pkt_s   long_pkt_i
  , input logic                long_v_i
  , output logic               long_yumi_o
  , output calc_pkg::wb_pkt_s  iwb_pkt_o
  );

  import calc_pkg::*;

  logic      iwb_v_r;
  reg_addr_t iwb_addr_r;
  word_t     iwb_data_r;

  // The long unit waits while the retire stage holds a result
  assign long_yumi_o = long_v_i & ~retire_pkt_i.ird_w_v;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      iwb_v_r <= 1'b0;
    else
      iwb_v_r <= retire_pkt_i.ird_w_v | long_yumi_o;
  end

  always_ff @(posedge clk_i)
  begin
    iwb_addr_r <= retire_pkt_i.ird_w_v ? retire_pkt_i.rd_addr : long_pkt_i.rd_addr;
    iwb_data_r <= retire_pkt_i.ird_w_v ? retire_pkt_i.rd_data : long_pkt_i.rd_data;
  end

  assign iwb_pkt_o = '{ird_w_v: iwb_v_r, rd_addr: iwb_addr_r, rd_data: iwb_data_r};

endmodule

`default_nettype wire

//--- src/calc_top.sv
`timescale 1ns/10ps
`default_nettype none

module calc_top
  (input logic                     clk_i
  , input logic                    rst_i
  , input calc_pkg::dispatch_pkt_s dispatch_pkt_i
  , output logic                   long_ready_o
  , output calc_pkg::wb_pkt_s      iwb_pkt_o
  );

  import calc_pkg::*;

  dispatch_pkt_s                reservation_r;
  wb_pkt_s [comp_stage_els-1:0] comp_stage;
  word_t [comp_stage_els-1:0]   comp_data_next;
  word_t                        int_data;
  word_t                        mul_data;
  logic                         int_v;
  logic                         mul_v;
  wb_pkt_s                      long_pkt;
  logic                         long_v;
  logic                         long_yumi;

  operand_bypass bypass
    (.clk_i(clk_i)
    ,.dispatch_pkt_i(dispatch_pkt_i)
    ,.comp_stage_i(comp_stage)
    ,.comp_data_next_i(comp_data_next)
    ,.reservation_o(reservation_r)
    );

  pipe_int int_pipe
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.reservation_i(reservation_r)
    ,.data_o(int_data)
    ,.v_o(int_v)
    );

  pipe_mul mul_pipe
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.reservation_i(reservation_r)
    ,.data_o(mul_data)
    ,.v_o(mul_v)
    );

  pipe_long long_pipe
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.reservation_i(reservation_r)
    ,.ready_o(long_ready_o)
    ,.wb_pkt_o(long_pkt)
    ,.v_o(long_v)
    ,.yumi_i(long_yumi)
    );

  // Stage 0 is filled from the dispatch on the same edge as the reservation
  completion_pipe comp_pipe
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.reservation_i(dispatch_pkt_i)
    ,.int_data_i(int_data)
    ,.int_v_i(int_v)
    ,.mul_data_i(mul_data)
    ,.mul_v_i(mul_v)
    ,.comp_stage_o(comp_stage)
    ,.comp_data_next_o(comp_data_next)
    );

  wb_arbiter arbiter
    (.clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.retire_pkt_i(comp_stage[comp_stage_els-1])
    ,.long_pkt_i(long_pkt)
    ,.long_v_i(long_v)
    ,.long_yumi_o(long_yumi)
    ,.iwb_pkt_o(iwb_pkt_o)
    );

endmodule

`default_nettype wire

//--- tb/calc_chk.sv
`timescale 1ns/10ps
`default_nettype none

module calc_chk
  (input logic                     clk_i
  , input logic                    rst_i
  , input calc_pkg::dispatch_pkt_s dispatch_pkt_i
  , input logic                    long_ready_o
  , input calc_pkg::wb_pkt_s       iwb_pkt_o
  );

  import calc_pkg::*;

  assert property (@(posedge clk_i) rst_i |=> !iwb_pkt_o.ird_w_v)
    else $error("writeback valid during reset");

  // Ready stays low from an accepted divide until its writeback
  assert property (@(posedge clk_i) disable iff (rst_i)
    (dispatch_pkt_i.valid && (dispatch_pkt_i.op == divu || dispatch_pkt_i.op == remu)
     && long_ready_o) |=> !long_ready_o)
    else $error("long unit ready after accepting a divide");

  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(long_ready_o) |-> iwb_pkt_o.ird_w_v)
    else $error("long unit ready again without a writeback");

  assert property (@(posedge clk_i) disable iff (rst_i)
    (dispatch_pkt_i.valid && dispatch_pkt_i.op != divu && dispatch_pkt_i.op != remu)
    |-> ##5 iwb_pkt_o.ird_w_v)
    else $error("fixed writeback lost");

endmodule

bind calc_top calc_chk chk
  (.clk_i(clk_i)
  ,.rst_i(rst_i)
  ,.dispatch_pkt_i(dispatch_pkt_i)
  ,.long_ready_o(long_ready_o)
  ,.iwb_pkt_o(iwb_pkt_o)
  );

`default_nettype wire

//--- tb/calc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module calc_tb;

  import calc_pkg::*;

  localparam int wait_limit = 100;

  logic          clk;
  logic          rst;
  dispatch_pkt_s disp;
  logic          long_ready;
  wb_pkt_s       iwb;

  // Reference model history with index 0 as the youngest dispatch
  logic      hist_v [4];
  reg_addr_t hist_rd [4];
  word_t     hist_res [4];
  int        due_q [$];
  wb_pkt_s   pkt_q [$];
  wb_pkt_s   div_exp;
  logic      div_pending;
  int        div_start;
  int        cyc;
  int        mismatch_cnt;
  int        other_cnt;

  int            fd;
  int            n;
  int            w;
  string         line;
  logic [31:0]   f_op;
  logic [31:0]   f_rd;
  logic [31:0]   f_rs1a;
  logic [31:0]   f_rs2a;
  logic [31:0]   f_rs1;
  logic [31:0]   f_rs2;
  logic [31:0]   f_gap;
  dispatch_pkt_s d;

  calc_top DUT
    (.clk_i(clk)
    ,.rst_i(rst)
    ,.dispatch_pkt_i(disp)
    ,.long_ready_o(long_ready)
    ,.iwb_pkt_o(iwb)
    );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    #400000;
    $display("Simulation did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic word_t op_result(op_e op, word_t a, word_t b);
    case (op)
      add:    return a + b;
      sub:    return a - b;
      and_op: return a & b;
      or_op:  return a | b;
      xor_op: return a ^ b;
      slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      mul:    return a * b;
      divu:   return (b == 0) ? '1 : a / b;
      remu:   return (b == 0) ? a : a % b;
      default: return '0;
    endcase
  endfunction

  task automatic check_wb(input wb_pkt_s act, input wb_pkt_s exp, input string name);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_ready(input logic act, input logic exp);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("Mismatch at %0t: long_ready_o is %b, expected %b", $time, act, exp);
    end
  endtask

  task automatic check_outputs();
    if (due_q.size() > 0 && due_q[0] == cyc)
    begin
      check_wb(iwb, pkt_q[0], "iwb_pkt_o");
      void'(due_q.pop_front());
      void'(pkt_q.pop_front());
    end
    else if (iwb.ird_w_v && div_pending)
    begin
      check_wb(iwb, div_exp, "iwb_pkt_o");
      div_pending = 1'b0;
    end
    else if (iwb.ird_w_v)
    begin
      other_cnt++;
      $display("At %0t a writeback appeared with no operation pending", $time);
    end
    if (div_pending && (cyc - div_start) > wait_limit)
    begin
      other_cnt++;
      $display("At %0t the divide writeback did not arrive in time", $time);
      div_pending = 1'b0;
    end
    check_ready(long_ready, ~div_pending);
  endtask

  // Drive one dispatch at the falling edge and advance the model by one cycle
  task automatic step(input dispatch_pkt_s p);
    word_t   a;
    word_t   b;
    word_t   res;
    logic    fa;
    logic    fb;
    logic    long_op;
    wb_pkt_s exp_pkt;
    a       = p.rs1;
    b       = p.rs2;
    fa      = 1'b0;
    fb      = 1'b0;
    long_op = (p.op == divu) || (p.op == remu);
    for (int i = 0; i < 4; i++)
    begin
      if (!fa && hist_v[i] && hist_rd[i] == p.rs1_addr)
      begin
        a  = hist_res[i];
        fa = 1'b1;
      end
      if (!fb && hist_v[i] && hist_rd[i] == p.rs2_addr)
      begin
        b  = hist_res[i];
        fb = 1'b1;
      end
    end
    res = op_result(p.op, a, b);
    for (int i = 3; i > 0; i--)
    begin
      hist_v[i]   = hist_v[i-1];
      hist_rd[i]  = hist_rd[i-1];
      hist_res[i] = hist_res[i-1];
    end
    hist_v[0]   = p.valid & ~long_op;
    hist_rd[0]  = p.rd_addr;
    hist_res[0] = res;
    exp_pkt     = '{ird_w_v: 1'b1, rd_addr: p.rd_addr, rd_data: res};
    // Visible on the writeback port after the fourth edge past the sampling edge
    if (p.valid && !long_op)
    begin
      due_q.push_back(cyc + 5);
      pkt_q.push_back(exp_pkt);
    end
    else if (p.valid)
    begin
      div_exp     = exp_pkt;
      div_pending = 1'b1;
      div_start   = cyc;
    end
    disp = p;
    @(negedge clk);
    cyc++;
    check_outputs();
  endtask

  initial
  begin
    rst          = 1'b1;
    disp         = '0;
    cyc          = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    div_pending  = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      hist_v[i]   = 1'b0;
      hist_rd[i]  = '0;
      hist_res[i] = '0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    fd = $fopen("tb/calc_cases.txt", "r");
    if (fd == 0)
    begin
      other_cnt++;
      $display("Could not open the cases file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        void'($fgets(line, fd));
        n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_rd, f_rs1a, f_rs2a,
                    f_rs1, f_rs2, f_gap);
        if (n == 7)
        begin
          d = '{valid: 1'b1, op: op_e'(f_op[3:0]), rd_addr: f_rd[4:0],
                rs1_addr: f_rs1a[4:0], rs2_addr: f_rs2a[4:0], rs1: f_rs1, rs2: f_rs2};
          if (d.op == divu || d.op == remu)
          begin
            w = 0;
            while (!long_ready && w < wait_limit)
            begin
              step('0);
              w++;
            end
            if (!long_ready)
            begin
              other_cnt++;
              $display("At %0t the long unit never became ready", $time);
            end
          end
          step(d);
          repeat (f_gap) step('0);
        end
      end
      $fclose(fd);
    end
    w = 0;
    while ((due_q.size() > 0 || div_pending) && w < wait_limit)
    begin
      step('0);
      w++;
    end
    if (due_q.size() > 0 || div_pending)
    begin
      other_cnt++;
      $display("At %0t writebacks were still outstanding at the end", $time);
    end
    $display("Closing: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/calc_cases.txt
// op rd rs1_addr rs2_addr rs1 rs2 gap, all hex
// op: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 mul 7 divu 8 remu
0 01 00 00 00000005 00000003 0
1 02 00 00 00000005 00000007 0
2 03 00 00 f0f0ff00 0ff0f0f0 0
3 04 00 00 f0f0ff00 0ff0f0f0 0
4 05 00 00 f0f0ff00 0ff0f0f0 0
5 06 00 00 ffffffff 00000001 2
0 08 00 00 00000010 00000020 0
0 09 08 08 00000000 00000000 0
1 0a 09 08 00000000 00000000 0
0 08 00 00 00000001 00000001 0
0 0b 08 0a 00000000 00000005 3
6 0c 00 00 00001234 00005678 0
6 0d 00 00 ffffffff ffffffff 0
6 0e 00 00 80000000 00000003 4
7 0f 00 00 00000064 00000007 0
8 10 00 00 00000064 00000007 0
7 11 00 00 12345678 00000000 0
8 12 00 00 12345678 00000000 1c
0 13 00 00 00000001 00000002 0
1 14 13 00 00000000 00000001 0
4 15 14 13 00000000 00000000 0
3 16 15 14 00000000 00000000 0
2 17 16 13 00000000 00000000 0
0 18 17 16 00000000 00000000 0

//--- list.f
src/calc_pkg.sv
src/operand_bypass.sv
src/pipe_int.sv
src/pipe_mul.sv
src/pipe_long.sv
src/completion_pipe.sv
src/wb_arbiter.sv
src/calc_top.sv
tb/calc_chk.sv
tb/calc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module calc_tb -o calc_sim

./obj_dir/calc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  exit 0
fi
exit 1
